//--- test/pcie_top_trace.txt
# W page full_mask part_mask d0..d7 | C as W, sent with the next read (same page)
# R page expected slots 0..7 | S address outside the register region
W 0 0f 00 00000010 00000011 10000000 00000001 aaaaaaaa bbbbbbbb cccccccc dddddddd
R 0 00000010 00000011 10000000 00000001 00000000 00000000 00000000 00000000
W 1 ff 00 00000101 00000102 20001000 00000002 00000040 0000ffff 80000000 00000003
W 5 0f 00 00000501 00000502 20005000 00000005 00000000 00000000 00000000 00000000
W f 0f 00 00000f01 00000f02 2000f000 0000000f 00000000 00000000 00000000 00000000
R 1 00000101 00000102 20001000 00000002 00000040 00000000 80000000 00000003
R 5 00000501 00000502 20005000 00000005 00000040 00000000 80000000 00000003
R f 00000f01 00000f02 2000f000 0000000f 00000040 00000000 80000000 00000003
W 5 4d 92 00000511 deadbeef 21005000 00000006 11111111 00000000 90000000 22222222
R 5 00000511 00000502 21005000 00000006 00000040 00000000 90000000 00000003
R 1 00000101 00000102 20001000 00000002 00000040 00000000 90000000 00000003
S 10000
R f 00000f01 00000f02 2000f000 0000000f 00000040 00000000 90000000 00000003
S 3ffc0
C 1 1f 00 00000121 00000122 20001200 00000012 00000077 00000000 00000000 00000000
R 1 00000121 00000122 20001200 00000012 00000077 00000000 90000000 00000003
C f c1 00 00000f31 00000000 00000000 00000000 00000000 00000000 a0000000 0000000a
R f 00000f31 00000f02 2000f000 0000000f 00000077 00000000 a0000000 0000000a
R 5 00000511 00000502 21005000 00000006 00000077 00000000 a0000000 0000000a
R 0 00000010 00000011 10000000 00000001 00000077 00000000 a0000000 0000000a

//--- pcie_top.f
design/pcie_regs_pkg.sv
design/pcie_reg_ifs.sv
design/mmio_decoder.sv
design/queue_table.sv
design/c2f_ring_regs.sv
design/readback_mux.sv
design/pcie_top.sv
test/tb_clock_gen.sv
test/pcie_top_checker.sv
test/pcie_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the pcie_top testbench with Verilator, run it, judge the result from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pcie_top_tb -f pcie_top.f \
    -o pcie_top_sim \
    && ./obj_dir/pcie_top_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see sim.log"; exit 1; }

cat sim.log
grep -q "TEST FAILED" sim.log && { echo "simulation reported a failure"; exit 1; }
echo "simulation finished without failures"
exit 0

//--- test/pcie_top_tb.sv
module pcie_top_tb;
    import pcie_regs_pkg::*;

    localparam int MAX_REC = 64;
    // cycles allowed for read data once the read has left the bus
    localparam int RD_WAIT = 12;

    logic       pcie_clk;
    logic       pcie_reset_n;
    pcie_addr_t pcie_address;
    logic       pcie_read;
    logic       pcie_write;
    line_t      pcie_writedata;
    byte_en_t   pcie_byteenable;
    line_t      pcie_readdata;
    logic       pcie_readdatavalid;

    // trace records: kind, page, slot masks, stray address, dwords
    logic [7:0] rec_kind [MAX_REC];
    logic [3:0] rec_page [MAX_REC];
    slot_mask_t rec_full [MAX_REC];
    slot_mask_t rec_part [MAX_REC];
    pcie_addr_t rec_addr [MAX_REC];
    dword_t     rec_dw   [MAX_REC][NB_SLOTS];

    int nrec         = 0;
    int seed         = 32'hc3ab_0903;
    int cycles       = 0;
    int cycle_limit  = 0;
    int checks       = 0;
    int errors       = 0;
    int valid_cnt    = 0;
    int region_reads = 0;
    // write record held back for the next read, -1 if none
    int pending      = -1;

    tb_clock_gen clk_gen (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n)
    );

    pcie_top DUT (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .pcie_address       (pcie_address),
        .pcie_read          (pcie_read),
        .pcie_write         (pcie_write),
        .pcie_writedata     (pcie_writedata),
        .pcie_byteenable    (pcie_byteenable),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid)
    );

    always @(posedge pcie_clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles without finishing the trace", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    always @(negedge pcie_clk) begin
        if (pcie_reset_n && pcie_readdatavalid) begin
            valid_cnt++;
        end
    end

    function automatic bit load_trace();
        int               fd;
        int               code;
        bit               ok;
        logic [7:0]       kind;
        logic [8*128-1:0] skip;
        fd = $fopen("test/pcie_top_trace.txt", "r");
        if (fd == 0) begin
            return 1'b0;
        end
        ok = 1'b1;
        while (nrec < MAX_REC && $fscanf(fd, " %c", kind) == 1) begin
            if (kind == "#") begin
                code = $fgets(skip, fd);
            end else begin
                rec_kind[nrec] = kind;
                if (kind == "S") begin
                    code = $fscanf(fd, "%h", rec_addr[nrec]);
                    ok   = ok && (code == 1);
                end else begin
                    code = $fscanf(fd, "%h", rec_page[nrec]);
                    ok   = ok && (code == 1);
                    if (kind != "R") begin
                        code = $fscanf(fd, "%h %h", rec_full[nrec], rec_part[nrec]);
                        ok   = ok && (code == 2);
                    end
                    for (int i = 0; i < NB_SLOTS; i++) begin
                        code = $fscanf(fd, "%h", rec_dw[nrec][i]);
                        ok   = ok && (code == 1);
                    end
                end
                nrec++;
            end
        end
        $fclose(fd);
        return ok && nrec > 0;
    endfunction

    function automatic pcie_addr_t page_addr(input logic [3:0] page);
        return pcie_addr_t'(32'(page) << PAGE_LSB);
    endfunction

    function automatic string result_word(input int err_before);
        return (errors == err_before) ? "ok" : "has errors";
    endfunction

    task automatic check_dword(input string what, input dword_t actual, input dword_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_kmem(input string what, input kmem_addr_t actual,
                              input kmem_addr_t expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $random(seed) & 32'h3;
        repeat (gap) @(negedge pcie_clk);
    endtask

    // full slots get all byte enables, partial slots one to three
    task automatic drive_write(input int r);
        logic [REG_BYTES-1:0] part_be;
        pcie_write      = 1'b1;
        pcie_address    = page_addr(rec_page[r]);
        pcie_writedata  = '0;
        pcie_byteenable = '0;
        for (int i = 0; i < NB_SLOTS; i++) begin
            part_be = REG_BYTES'(($random(seed) & 32'h7) | 32'h1);
            pcie_writedata[i*DWORD_W +: DWORD_W] = rec_dw[r][i];
            if (rec_full[r][i]) begin
                pcie_byteenable[i*REG_BYTES +: REG_BYTES] = '1;
            end else if (rec_part[r][i]) begin
                pcie_byteenable[i*REG_BYTES +: REG_BYTES] = part_be;
            end
        end
    endtask

    task automatic do_write(input int r);
        @(negedge pcie_clk);
        drive_write(r);
        @(negedge pcie_clk);
        pcie_write = 1'b0;
        $display("record %0d: write to page %0h done", r, rec_page[r]);
    endtask

    task automatic check_read(input int r);
        for (int i = 0; i < SLOT_KMEM_L; i++) begin
            check_dword($sformatf("page %0h slot %0d", rec_page[r], i),
                        pcie_readdata[i*DWORD_W +: DWORD_W], rec_dw[r][i]);
        end
        check_kmem($sformatf("page %0h kernel address", rec_page[r]),
                   pcie_readdata[SLOT_KMEM_L*DWORD_W +: 2*DWORD_W],
                   {rec_dw[r][SLOT_KMEM_H], rec_dw[r][SLOT_KMEM_L]});
        // upper half of the line carries no registers
        for (int i = NB_SLOTS; i < LINE_W / DWORD_W; i++) begin
            check_dword($sformatf("page %0h upper slot %0d", rec_page[r], i),
                        pcie_readdata[i*DWORD_W +: DWORD_W], '0);
        end
    endtask

    task automatic do_read(input int r);
        int err_before;
        bit got;
        err_before = errors;
        got        = 1'b0;
        @(negedge pcie_clk);
        if (pending >= 0) begin
            drive_write(pending);
        end
        pcie_read    = 1'b1;
        pcie_address = page_addr(rec_page[r]);
        @(negedge pcie_clk);
        pcie_read = 1'b0;
        // a held write stays on the bus one more cycle
        @(negedge pcie_clk);
        pcie_write = 1'b0;
        pending    = -1;
        for (int w = 0; w < RD_WAIT && !got; w++) begin
            @(negedge pcie_clk);
            got = pcie_readdatavalid;
        end
        region_reads++;
        if (got) begin
            check_read(r);
        end else begin
            errors++;
            $display("record %0d: no read data returned", r);
        end
        $display("record %0d: read of page %0h %s", r, rec_page[r], result_word(err_before));
    endtask

    task automatic do_stray(input int r);
        int err_before;
        bit seen;
        err_before = errors;
        seen       = 1'b0;
        @(negedge pcie_clk);
        pcie_read    = 1'b1;
        pcie_address = rec_addr[r];
        @(negedge pcie_clk);
        pcie_read = 1'b0;
        repeat (RD_WAIT) begin
            @(negedge pcie_clk);
            seen = seen | pcie_readdatavalid;
        end
        if (seen) begin
            errors++;
            $display("record %0d: read at %h outside the register region returned data",
                     r, rec_addr[r]);
        end
        $display("record %0d: stray read at %h %s", r, rec_addr[r], result_word(err_before));
    endtask

    initial begin
        pcie_address    = '0;
        pcie_read       = 1'b0;
        pcie_write      = 1'b0;
        pcie_writedata  = '0;
        pcie_byteenable = '0;
        if (!load_trace()) begin
            $display("trace file test/pcie_top_trace.txt is missing, empty or malformed");
            $display("TEST FAILED");
            $finish;
        end else begin
            cycle_limit = 20 * nrec + 100;
            @(posedge pcie_reset_n);
            for (int r = 0; r < nrec; r++) begin
                idle_gap();
                case (rec_kind[r])
                    "W": do_write(r);
                    "C": pending = r;
                    "R": do_read(r);
                    "S": do_stray(r);
                    default: begin
                        errors++;
                        $display("record %0d: unknown record kind %c", r, rec_kind[r]);
                    end
                endcase
            end
            // let the last valid be counted and any late read data show up
            repeat (RD_WAIT) @(negedge pcie_clk);
            if (valid_cnt != region_reads) begin
                errors++;
                $display("read data returned %0d times for %0d register reads",
                         valid_cnt, region_reads);
            end
            $display("records %0d, checks %0d, errors %0d", nrec, checks, errors);
            if (errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

//--- test/pcie_top_checker.sv
module pcie_top_checker (
    input logic pcie_clk,
    input logic pcie_reset_n,
    input logic wr_stb,
    input logic rd_issue,
    input logic pcie_readdatavalid
);

    // one table port, so a cycle carries a write or a read
    a_no_wr_rd_overlap: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n) !(wr_stb && rd_issue)
    ) else $error("wr_stb and rd_issue high in the same cycle");

    a_no_valid_in_reset: assert property (
        @(posedge pcie_clk) !pcie_reset_n |=> !pcie_readdatavalid
    ) else $error("pcie_readdatavalid high during reset");

    // at most one read outstanding, valid is a single pulse
    a_valid_single_cycle: assert property (
        @(posedge pcie_clk) disable iff (!pcie_reset_n)
            pcie_readdatavalid |=> !pcie_readdatavalid
    ) else $error("pcie_readdatavalid high two cycles in a row");

endmodule

bind pcie_top pcie_top_checker u_checker (
    .pcie_clk           (pcie_clk),
    .pcie_reset_n       (pcie_reset_n),
    .wr_stb             (req_if.wr_stb),
    .rd_issue           (req_if.rd_issue),
    .pcie_readdatavalid (pcie_readdatavalid)
);

//--- test/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,
    parameter int RESET_CYCLES = 4
) (
    output logic pcie_clk,
    output logic pcie_reset_n
);

    initial begin
        pcie_clk = 1'b0;
        forever #HALF_PERIOD pcie_clk = ~pcie_clk;
    end

    // released on a falling edge, away from the sampling edge
    initial begin
        pcie_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge pcie_clk);
        @(negedge pcie_clk);
        pcie_reset_n = 1'b1;
    end

endmodule

//--- design/pcie_top.sv
module pcie_top #(
    parameter int APP_IDX_W = 4
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  pcie_regs_pkg::pcie_addr_t  pcie_address,
    input  logic                       pcie_read,
    input  logic                       pcie_write,
    input  pcie_regs_pkg::line_t       pcie_writedata,
    input  pcie_regs_pkg::byte_en_t    pcie_byteenable,
    output pcie_regs_pkg::line_t       pcie_readdata,
    output logic                       pcie_readdatavalid
);
    import pcie_regs_pkg::*;

    dword_t     c2f_tail;
    kmem_addr_t c2f_kmem_addr;

    mmio_req_if #(.APP_IDX_W(APP_IDX_W)) req_if ();
    qt_read_if rd_if ();

    // host request side
    mmio_decoder #(.APP_IDX_W(APP_IDX_W)) u_decoder (
        .pcie_clk        (pcie_clk),
        .pcie_reset_n    (pcie_reset_n),
        .pcie_address    (pcie_address),
        .pcie_read       (pcie_read),
        .pcie_write      (pcie_write),
        .pcie_writedata  (pcie_writedata),
        .pcie_byteenable (pcie_byteenable),
        .req             (req_if.src)
    );

    queue_table #(.APP_IDX_W(APP_IDX_W)) u_queue_table (
        .pcie_clk     (pcie_clk),
        .pcie_reset_n (pcie_reset_n),
        .req          (req_if.sink),
        .rd           (rd_if.src)
    );

    c2f_ring_regs u_c2f_regs (
        .pcie_clk      (pcie_clk),
        .pcie_reset_n  (pcie_reset_n),
        .req           (req_if.sink),
        .c2f_tail      (c2f_tail),
        .c2f_kmem_addr (c2f_kmem_addr)
    );

    // read line back to the host
    readback_mux u_readback (
        .pcie_clk           (pcie_clk),
        .pcie_reset_n       (pcie_reset_n),
        .rd                 (rd_if.sink),
        .c2f_tail           (c2f_tail),
        .c2f_kmem_addr      (c2f_kmem_addr),
        .pcie_readdata      (pcie_readdata),
        .pcie_readdatavalid (pcie_readdatavalid)
    );

endmodule

//--- design/readback_mux.sv
module readback_mux (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    qt_read_if.sink                    rd,
    input  pcie_regs_pkg::dword_t      c2f_tail,
    input  pcie_regs_pkg::kmem_addr_t  c2f_kmem_addr,
    output pcie_regs_pkg::line_t       pcie_readdata,
    output logic                       pcie_readdatavalid
);
    import pcie_regs_pkg::*;

    line_t line_next;

    // slots in slot order, upper half of the line stays zero
    always_comb begin
        line_next = '0;
        line_next[SLOT_TAIL*DWORD_W     +: DWORD_W] = rd.tail;
        line_next[SLOT_HEAD*DWORD_W     +: DWORD_W] = rd.head;
        line_next[SLOT_L_ADDR*DWORD_W   +: DWORD_W] = rd.l_addr;
        line_next[SLOT_H_ADDR*DWORD_W   +: DWORD_W] = rd.h_addr;
        line_next[SLOT_C2F_TAIL*DWORD_W +: DWORD_W] = c2f_tail;
        // no c2f head register on this card
        line_next[SLOT_C2F_HEAD*DWORD_W +: DWORD_W] = '0;
        line_next[SLOT_KMEM_L*DWORD_W   +: DWORD_W] = c2f_kmem_addr[DWORD_W-1:0];
        line_next[SLOT_KMEM_H*DWORD_W   +: DWORD_W] = c2f_kmem_addr[2*DWORD_W-1:DWORD_W];
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            pcie_readdata      <= '0;
            pcie_readdatavalid <= 1'b0;
        end else begin
            pcie_readdatavalid <= rd.rd_valid;
            // hold the last line between reads
            if (rd.rd_valid) begin
                pcie_readdata <= line_next;
            end
        end
    end

endmodule

//--- design/c2f_ring_regs.sv
module c2f_ring_regs (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    mmio_req_if.sink                   req,
    output pcie_regs_pkg::dword_t      c2f_tail,
    output pcie_regs_pkg::kmem_addr_t  c2f_kmem_addr
);
    import pcie_regs_pkg::*;

    // single global ring, written from any page
    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            c2f_tail      <= '0;
            c2f_kmem_addr <= '0;
        end else if (req.wr_stb) begin
            if (req.slot_hit[SLOT_C2F_TAIL]) begin
                c2f_tail <= req.wr_data[SLOT_C2F_TAIL*DWORD_W +: DWORD_W];
            end
            // each half of the kernel address has its own slot
            if (req.slot_hit[SLOT_KMEM_L]) begin
                c2f_kmem_addr[DWORD_W-1:0] <=
                    req.wr_data[SLOT_KMEM_L*DWORD_W +: DWORD_W];
            end
            if (req.slot_hit[SLOT_KMEM_H]) begin
                c2f_kmem_addr[2*DWORD_W-1:DWORD_W] <=
                    req.wr_data[SLOT_KMEM_H*DWORD_W +: DWORD_W];
            end
        end
    end

endmodule

//--- design/queue_table.sv
module queue_table #(
    parameter int APP_IDX_W = 4
) (
    input  logic       pcie_clk,
    input  logic       pcie_reset_n,
    mmio_req_if.sink   req,
    qt_read_if.src     rd
);
    import pcie_regs_pkg::*;

    // tail, head, low and high kernel address
    localparam int NB_BANKS = 4;
    localparam int DEPTH    = 2 ** APP_IDX_W;

    dword_t     bank_mem [NB_BANKS][DEPTH];
    dword_t     bank_q   [NB_BANKS];
    dword_t     out_q    [NB_BANKS];
    logic [1:0] vld_q;

    // bank b holds slot SLOT_TAIL + b of every page
    always_ff @(posedge pcie_clk) begin
        for (int b = 0; b < NB_BANKS; b++) begin
            if (req.wr_stb && req.slot_hit[SLOT_TAIL + b]) begin
                bank_mem[b][req.page_idx] <=
                    req.wr_data[(SLOT_TAIL + b)*DWORD_W +: DWORD_W];
            end

            // memory read register
            if (req.rd_issue) begin
                bank_q[b] <= bank_mem[b][req.page_idx];
            end

            // output register
            if (vld_q[0]) begin
                out_q[b] <= bank_q[b];
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[0], req.rd_issue};
        end
    end

    assign rd.rd_valid = vld_q[1];
    assign rd.tail     = out_q[SLOT_TAIL   - SLOT_TAIL];
    assign rd.head     = out_q[SLOT_HEAD   - SLOT_TAIL];
    assign rd.l_addr   = out_q[SLOT_L_ADDR - SLOT_TAIL];
    assign rd.h_addr   = out_q[SLOT_H_ADDR - SLOT_TAIL];

endmodule

//--- design/mmio_decoder.sv
module mmio_decoder #(
    parameter int APP_IDX_W = 4
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  pcie_regs_pkg::pcie_addr_t  pcie_address,
    input  logic                       pcie_read,
    input  logic                       pcie_write,
    input  pcie_regs_pkg::line_t       pcie_writedata,
    input  pcie_regs_pkg::byte_en_t    pcie_byteenable,
    mmio_req_if.src                    req
);
    import pcie_regs_pkg::*;

    // byte offset bits of a 512-bit line
    localparam int LINE_LSB   = $clog2(BE_W);
    localparam int LINE_IDX_W = PCIE_ADDR_W - LINE_LSB;

    logic [APP_IDX_W-1:0] page_in;
    logic                 reg_region;
    logic                 rd_accept;
    logic                 rd_go;
    slot_mask_t           slot_full;

    rd_state_t            rd_state;
    logic                 wr_stb_q;
    slot_mask_t           slot_hit_q;
    line_t                wr_data_q;
    logic [APP_IDX_W-1:0] wr_page_q;
    logic [APP_IDX_W-1:0] rd_page_q;

    assign page_in    = pcie_address[PAGE_LSB +: APP_IDX_W];
    assign reg_region = pcie_address[PCIE_ADDR_W-1:LINE_LSB] < LINE_IDX_W'(RB_BRAM_OFFSET);
    assign rd_accept  = pcie_read && reg_region;

    // partial slot writes are dropped
    always_comb begin
        for (int i = 0; i < NB_SLOTS; i++) begin
            slot_full[i] = &pcie_byteenable[i*REG_BYTES +: REG_BYTES];
        end
    end

    // the table has one host port, a write strobe always wins
    assign rd_go = (rd_state == RD_PENDING) && !wr_stb_q;

    always_ff @(posedge pcie_clk) begin
        if (!pcie_reset_n) begin
            wr_stb_q <= 1'b0;
            rd_state <= RD_IDLE;
        end else begin
            wr_stb_q <= pcie_write;
            if (rd_accept) begin
                rd_state <= RD_PENDING;
            end else if (rd_go) begin
                rd_state <= RD_IDLE;
            end
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (pcie_write) begin
            slot_hit_q <= slot_full;
            wr_data_q  <= pcie_writedata;
            wr_page_q  <= page_in;
        end
        if (rd_accept) begin
            rd_page_q <= page_in;
        end
    end

    assign req.wr_stb   = wr_stb_q;
    assign req.slot_hit = slot_hit_q;
    assign req.wr_data  = wr_data_q;
    assign req.page_idx = wr_stb_q ? wr_page_q : rd_page_q;
    assign req.rd_issue = rd_go;

endmodule

//--- design/pcie_reg_ifs.sv
// decoded host request, shared by table and ring registers
interface mmio_req_if #(
    parameter int APP_IDX_W = 4
);
    import pcie_regs_pkg::*;

    logic                 wr_stb;
    slot_mask_t           slot_hit;
    line_t                wr_data;
    // write page while wr_stb is high, pending read page otherwise
    logic [APP_IDX_W-1:0] page_idx;
    logic                 rd_issue;

    modport src (
        output wr_stb,
        output slot_hit,
        output wr_data,
        output page_idx,
        output rd_issue
    );

    modport sink (
        input wr_stb,
        input slot_hit,
        input wr_data,
        input page_idx,
        input rd_issue
    );

endinterface

// queue table read result, all four banks at once
interface qt_read_if;
    import pcie_regs_pkg::*;

    logic   rd_valid;
    dword_t tail;
    dword_t head;
    dword_t l_addr;
    dword_t h_addr;

    modport src (
        output rd_valid,
        output tail,
        output head,
        output l_addr,
        output h_addr
    );

    modport sink (
        input rd_valid,
        input tail,
        input head,
        input l_addr,
        input h_addr
    );

endinterface

//--- design/pcie_regs_pkg.sv
package pcie_regs_pkg;

    // data path widths
    parameter int DWORD_W     = 32;
    parameter int LINE_W      = 512;
    parameter int BE_W        = 64;
    parameter int REG_BYTES   = 4;

    // host address map
    parameter int PCIE_ADDR_W    = 18;
    parameter int PAGE_LSB       = 12;
    // first 512-bit line past the register region (64 KiB)
    parameter int RB_BRAM_OFFSET = 1024;

    // slot map inside one 512-bit line
    parameter int NB_SLOTS      = 8;
    parameter int SLOT_TAIL     = 0;
    parameter int SLOT_HEAD     = 1;
    parameter int SLOT_L_ADDR   = 2;
    parameter int SLOT_H_ADDR   = 3;
    parameter int SLOT_C2F_TAIL = 4;
    // reserved, always reads back as zero
    parameter int SLOT_C2F_HEAD = 5;
    parameter int SLOT_KMEM_L   = 6;
    parameter int SLOT_KMEM_H   = 7;

    typedef logic [DWORD_W-1:0]     dword_t;
    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [BE_W-1:0]        byte_en_t;
    typedef logic [PCIE_ADDR_W-1:0] pcie_addr_t;
    typedef logic [2*DWORD_W-1:0]   kmem_addr_t;
    // one bit per slot, set when all byte enables of the slot are set
    typedef logic [NB_SLOTS-1:0]    slot_mask_t;

    typedef enum logic {
        RD_IDLE,
        RD_PENDING
    } rd_state_t;

endpackage
